// ==== l2_tag_pipe.f ====
logic/l2_cache_pkg.sv
logic/l2_req_pkg.sv
logic/l2_tag_sram.sv
logic/l2_tag_lookup.sv
logic/l2_tag_compare.sv
logic/l2_tag_update.sv
logic/l2_tag_pipe.sv
testbench/l2_tag_pipe_assertions.sv
testbench/l2_tag_pipe_tb.sv

// ==== logic/l2_cache_pkg.sv ====
// L2 tag geometry and the way-entry format, shared by the tag RAMs and every pipeline stage
`default_nettype none

package l2_cache_pkg;

    // 512 sets x 4 ways, 18-bit tags
    localparam int L2_INDEX_BITS = 9;                 // set index width
    localparam int L2_TAG_BITS   = 18;                // tag width
    localparam int L2_WAYS       = 4;                 // associativity

    // set index into every tag RAM
    typedef logic [L2_INDEX_BITS-1:0] index_t;

    // address tag as stored per way
    typedef logic [L2_TAG_BITS-1:0] tag_t;

    // way number, 0..3
    typedef logic [$clog2(L2_WAYS)-1:0] way_t;

    // one way of one set, 20 bits
    typedef struct packed {
        logic valid;                                  // entry holds a line
        logic dirty;                                  // line modified since fill
        tag_t tag;                                    // line tag
    } l2_tag_entry_t;

endpackage

`default_nettype wire

// ==== logic/l2_req_pkg.sv ====
// request opcodes and pseudo-LRU tree rules used by the compare and update stages
`default_nettype none

package l2_req_pkg;

    typedef enum logic [1:0] {
        OP_LOAD  = 2'd0,                              // read access
        OP_STORE = 2'd1,                              // write access, marks dirty
        OP_INVAL = 2'd2                               // drop the line if present
    } l2_op_t;

    // bit 0 picks the pair, bit 1 picks in ways 0/1, bit 2 picks in ways 2/3
    typedef logic [2:0] plru_t;

    // point every tree bit on the accessed way's path away from it
    function automatic plru_t plru_touch(
        input plru_t              plru,
        input l2_cache_pkg::way_t way
    );
        plru_t next;
        next = plru;
        case (way)
            2'd0: begin next[0] = 1'b1; next[1] = 1'b1; end
            2'd1: begin next[0] = 1'b1; next[1] = 1'b0; end
            2'd2: begin next[0] = 1'b0; next[2] = 1'b1; end
            default: begin next[0] = 1'b0; next[2] = 1'b0; end
        endcase
        return next;
    endfunction

    // free ways first (lowest number wins), otherwise follow the tree
    function automatic l2_cache_pkg::way_t plru_victim(
        input logic [l2_cache_pkg::L2_WAYS-1:0] valid,
        input plru_t                            plru
    );
        l2_cache_pkg::way_t way;
        if (!valid[0])      way = 2'd0;
        else if (!valid[1]) way = 2'd1;
        else if (!valid[2]) way = 2'd2;
        else if (!valid[3]) way = 2'd3;
        else if (plru[0])   way = plru[2] ? 2'd3 : 2'd2;   // upper pair
        else                way = plru[1] ? 2'd1 : 2'd0;   // lower pair
        return way;
    endfunction

endpackage

`default_nettype wire

// ==== logic/l2_tag_compare.sv ====
// stage 2 of the tag pipeline, tag match and victim selection with forwarding of the last write
`default_nettype none
`timescale 1ns/10ps

module l2_tag_compare (
    input  logic                                clk,
    input  logic                                rst_n,
    input  l2_cache_pkg::index_t                s1_index,
    input  l2_cache_pkg::tag_t                  s1_tag,
    input  l2_cache_pkg::l2_tag_entry_t         way_rd [l2_cache_pkg::L2_WAYS],
    input  l2_req_pkg::plru_t                   plru_rd,
    input  logic                                wr_en,
    input  l2_cache_pkg::index_t                wr_index,
    input  logic [l2_cache_pkg::L2_WAYS-1:0]    wr_way_en,
    input  l2_cache_pkg::l2_tag_entry_t         wr_entry,
    input  l2_req_pkg::plru_t                   wr_plru,
    output logic                                s2_hit,
    output l2_cache_pkg::way_t                  s2_hit_way,
    output l2_cache_pkg::way_t                  s2_victim_way,
    output l2_cache_pkg::l2_tag_entry_t         s2_victim_entry,
    output l2_req_pkg::plru_t                   s2_plru
);
    import l2_cache_pkg::*;
    import l2_req_pkg::*;

    logic                fwd_valid;                   // a write landed on the last edge
    index_t              fwd_index;
    logic [L2_WAYS-1:0]  fwd_way_en;
    l2_tag_entry_t       fwd_entry;
    plru_t               fwd_plru;

    logic                same_set;
    l2_tag_entry_t       cur_entry [L2_WAYS];         // RAM data merged with forwarded write
    logic [L2_WAYS-1:0]  valid_vec;
    logic [L2_WAYS-1:0]  hit_vec;

    // the RAM read of this cycle happened on the same edge as the write,
    // so it returned the old contents; keep a copy of that write for one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fwd_valid <= 1'b0;
        end else begin
            fwd_valid <= wr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            fwd_index  <= wr_index;
            fwd_way_en <= wr_way_en;
            fwd_entry  <= wr_entry;
            fwd_plru   <= wr_plru;
        end
    end

    assign same_set = fwd_valid && (fwd_index == s1_index);

    always_comb begin
        for (int w = 0; w < L2_WAYS; w++) begin
            cur_entry[w] = (same_set && fwd_way_en[w]) ? fwd_entry : way_rd[w];
            valid_vec[w] = cur_entry[w].valid;
            hit_vec[w]   = cur_entry[w].valid && (cur_entry[w].tag == s1_tag);
        end
    end

    // at most one way matches, encode it
    always_comb begin
        s2_hit_way = '0;
        for (int w = L2_WAYS - 1; w >= 0; w--) begin
            if (hit_vec[w]) begin
                s2_hit_way = way_t'(w);
            end
        end
    end

    assign s2_hit          = |hit_vec;
    assign s2_plru         = same_set ? fwd_plru : plru_rd;   // unwritten plru keeps RAM value
    assign s2_victim_way   = plru_victim(valid_vec, s2_plru);
    assign s2_victim_entry = cur_entry[s2_victim_way];        // checked for write-back

endmodule

`default_nettype wire

// ==== logic/l2_tag_lookup.sv ====
// stage 1 of the tag pipeline, accepts a request and starts the read of all tag RAMs
`default_nettype none
`timescale 1ns/10ps

module l2_tag_lookup (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 init_done,
    input  logic                 req_valid,
    input  l2_req_pkg::l2_op_t   req_op,
    input  l2_cache_pkg::index_t req_index,
    input  l2_cache_pkg::tag_t   req_tag,
    output logic                 rd_en,
    output l2_cache_pkg::index_t rd_index,
    output logic                 s1_valid,
    output l2_req_pkg::l2_op_t   s1_op,
    output l2_cache_pkg::index_t s1_index,
    output l2_cache_pkg::tag_t   s1_tag
);

    // requests during the clearing sweep are dropped
    assign rd_en    = req_valid && init_done;
    assign rd_index = req_index;                      // same set for all five RAMs

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= rd_en;
        end
    end

    // request fields line up with the RAM outputs of the same edge
    always_ff @(posedge clk) begin
        if (rd_en) begin
            s1_op    <= req_op;
            s1_index <= req_index;
            s1_tag   <= req_tag;
        end
    end

endmodule

`default_nettype wire

// ==== logic/l2_tag_pipe.sv ====
// top of the L2 tag pipeline, the three stages around four way RAMs and one PLRU RAM
`default_nettype none
`timescale 1ns/10ps

module l2_tag_pipe #(
    parameter int SETS = 512
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    input  l2_req_pkg::l2_op_t   req_op,
    input  l2_cache_pkg::index_t req_index,
    input  l2_cache_pkg::tag_t   req_tag,
    output logic                 init_done,
    output logic                 resp_valid,
    output logic                 resp_hit,
    output l2_cache_pkg::way_t   resp_way,
    output logic                 evict_valid,
    output l2_cache_pkg::tag_t   evict_tag
);
    import l2_cache_pkg::*;
    import l2_req_pkg::*;

    logic                rd_en;
    index_t              rd_index;
    logic                s1_valid;
    l2_op_t              s1_op;
    index_t              s1_index;
    tag_t                s1_tag;
    l2_tag_entry_t       way_rd [L2_WAYS];
    plru_t               plru_rd;
    logic                s2_hit;
    way_t                s2_hit_way;
    way_t                s2_victim_way;
    l2_tag_entry_t       s2_victim_entry;
    plru_t               s2_plru;
    logic                wr_en;                       // write bundle from stage 3
    index_t              wr_index;
    logic [L2_WAYS-1:0]  wr_way_en;
    l2_tag_entry_t       wr_entry;
    plru_t               wr_plru;

    l2_tag_lookup u_lookup (
        .clk       (clk),
        .rst_n     (rst_n),
        .init_done (init_done),
        .req_valid (req_valid),
        .req_op    (req_op),
        .req_index (req_index),
        .req_tag   (req_tag),
        .rd_en     (rd_en),
        .rd_index  (rd_index),
        .s1_valid  (s1_valid),
        .s1_op     (s1_op),
        .s1_index  (s1_index),
        .s1_tag    (s1_tag)
    );

    for (genvar w = 0; w < L2_WAYS; w++) begin : g_way
        l2_tag_sram #(
            .DEPTH   (SETS),
            .ENTRY_T (l2_tag_entry_t)
        ) u_way_ram (
            .clk      (clk),
            .rd_en    (rd_en),
            .rd_index (rd_index),
            .wr_en    (wr_en && wr_way_en[w]),        // only the selected way
            .wr_index (wr_index),
            .wr_data  (wr_entry),
            .rd_data  (way_rd[w])
        );
    end

    // tree is rewritten on every write, unchanged value when not touched
    l2_tag_sram #(
        .DEPTH   (SETS),
        .ENTRY_T (plru_t)
    ) u_plru_ram (
        .clk      (clk),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_data  (wr_plru),
        .rd_data  (plru_rd)
    );

    l2_tag_compare u_compare (
        .clk             (clk),
        .rst_n           (rst_n),
        .s1_index        (s1_index),
        .s1_tag          (s1_tag),
        .way_rd          (way_rd),
        .plru_rd         (plru_rd),
        .wr_en           (wr_en),
        .wr_index        (wr_index),
        .wr_way_en       (wr_way_en),
        .wr_entry        (wr_entry),
        .wr_plru         (wr_plru),
        .s2_hit          (s2_hit),
        .s2_hit_way      (s2_hit_way),
        .s2_victim_way   (s2_victim_way),
        .s2_victim_entry (s2_victim_entry),
        .s2_plru         (s2_plru)
    );

    l2_tag_update #(
        .DEPTH (SETS)
    ) u_update (
        .clk             (clk),
        .rst_n           (rst_n),
        .s1_valid        (s1_valid),
        .s1_op           (s1_op),
        .s1_index        (s1_index),
        .s1_tag          (s1_tag),
        .s2_hit          (s2_hit),
        .s2_hit_way      (s2_hit_way),
        .s2_victim_way   (s2_victim_way),
        .s2_victim_entry (s2_victim_entry),
        .s2_plru         (s2_plru),
        .init_done       (init_done),
        .wr_en           (wr_en),
        .wr_index        (wr_index),
        .wr_way_en       (wr_way_en),
        .wr_entry        (wr_entry),
        .wr_plru         (wr_plru),
        .resp_valid      (resp_valid),
        .resp_hit        (resp_hit),
        .resp_way        (resp_way),
        .evict_valid     (evict_valid),
        .evict_tag       (evict_tag)
    );

endmodule

`default_nettype wire

// ==== logic/l2_tag_sram.sv ====
// synchronous tag RAM, one read and one write port, instantiated per way and for the PLRU bits
`default_nettype none
`timescale 1ns/10ps

module l2_tag_sram #(
    parameter int  DEPTH   = 512,
    parameter type ENTRY_T = logic
) (
    input  logic                 clk,
    input  logic                 rd_en,
    input  l2_cache_pkg::index_t rd_index,
    input  logic                 wr_en,
    input  l2_cache_pkg::index_t wr_index,
    input  ENTRY_T               wr_data,
    output ENTRY_T               rd_data
);

    ENTRY_T mem [DEPTH];                              // contents cleared by the update stage

    // registered read, old data on a same-edge write
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_index] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/l2_tag_update.sv ====
// stage 3 of the tag pipeline, builds the RAM writes, clears the array after reset, drives the response
`default_nettype none
`timescale 1ns/10ps

module l2_tag_update #(
    parameter int DEPTH = 512
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                s1_valid,
    input  l2_req_pkg::l2_op_t                  s1_op,
    input  l2_cache_pkg::index_t                s1_index,
    input  l2_cache_pkg::tag_t                  s1_tag,
    input  logic                                s2_hit,
    input  l2_cache_pkg::way_t                  s2_hit_way,
    input  l2_cache_pkg::way_t                  s2_victim_way,
    input  l2_cache_pkg::l2_tag_entry_t         s2_victim_entry,
    input  l2_req_pkg::plru_t                   s2_plru,
    output logic                                init_done,
    output logic                                wr_en,
    output l2_cache_pkg::index_t                wr_index,
    output logic [l2_cache_pkg::L2_WAYS-1:0]    wr_way_en,
    output l2_cache_pkg::l2_tag_entry_t         wr_entry,
    output l2_req_pkg::plru_t                   wr_plru,
    output logic                                resp_valid,
    output logic                                resp_hit,
    output l2_cache_pkg::way_t                  resp_way,
    output logic                                evict_valid,
    output l2_cache_pkg::tag_t                  evict_tag
);
    import l2_cache_pkg::*;
    import l2_req_pkg::*;

    index_t sweep_idx;                                // set being cleared
    way_t   acc_way;                                  // way touched by a load or store
    logic   fill;                                     // miss that allocates the victim
    logic   evict;

    assign acc_way = s2_hit ? s2_hit_way : s2_victim_way;
    assign fill    = s1_valid && !s2_hit && (s1_op != OP_INVAL);
    assign evict   = fill && s2_victim_entry.valid && s2_victim_entry.dirty;

    always_comb begin
        wr_en     = 1'b0;
        wr_index  = s1_index;
        wr_way_en = '0;
        wr_entry  = '{valid: 1'b1, dirty: (s1_op == OP_STORE), tag: s1_tag};
        wr_plru   = s2_plru;
        if (!init_done) begin
            // clear all ways and the tree of one set per cycle
            wr_en     = 1'b1;
            wr_index  = sweep_idx;
            wr_way_en = '1;
            wr_entry  = '0;
            wr_plru   = '0;
        end else if (s1_valid) begin
            case (s1_op)
                OP_LOAD, OP_STORE: begin
                    wr_en   = 1'b1;
                    wr_plru = plru_touch(s2_plru, acc_way);
                    if (!s2_hit || s1_op == OP_STORE) begin
                        wr_way_en = L2_WAYS'(1) << acc_way;   // load hit leaves the entry alone
                    end
                end
                OP_INVAL: begin
                    if (s2_hit) begin
                        wr_en     = 1'b1;
                        wr_way_en = L2_WAYS'(1) << s2_hit_way;
                        wr_entry  = '{valid: 1'b0, dirty: 1'b0, tag: s1_tag};
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sweep_idx   <= '0;
            init_done   <= 1'b0;
            resp_valid  <= 1'b0;
            evict_valid <= 1'b0;
        end else begin
            if (!init_done) begin
                sweep_idx <= sweep_idx + 1'b1;
                if (sweep_idx == index_t'(DEPTH - 1)) begin
                    init_done <= 1'b1;                // stays high until reset
                end
            end
            resp_valid  <= s1_valid;
            evict_valid <= evict;
        end
    end

    // response fields, valid alongside resp_valid
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            resp_hit  <= s2_hit;
            resp_way  <= (s2_hit || s1_op == OP_INVAL) ? s2_hit_way : s2_victim_way;
            evict_tag <= s2_victim_entry.tag;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/l2_tag_pipe_assertions.sv ====
// port-level protocol checks for the L2 tag pipeline, bound into every l2_tag_pipe instance
`default_nettype none
`timescale 1ns/10ps

module l2_tag_pipe_assertions (
    input  logic clk,
    input  logic rst_n,
    input  logic req_valid,
    input  logic init_done,
    input  logic resp_valid,
    input  logic resp_hit,
    input  logic evict_valid
);

    int unsigned fail_count = 0;                      // polled by the testbench
    logic        accepted;

    assign accepted = req_valid && init_done;         // requests during the sweep are dropped

    // fixed latency of two rising edges
    a_resp_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
        accepted |-> ##2 resp_valid)
        else begin
            fail_count = fail_count + 1;
            $error("accepted request got no response two edges later");
        end

    a_resp_has_cause: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> $past(accepted, 2))
        else begin
            fail_count = fail_count + 1;
            $error("response without an accepted request two edges earlier");
        end

    a_evict_on_miss: assert property (@(posedge clk) disable iff (!rst_n)
        evict_valid |-> (resp_valid && !resp_hit))
        else begin
            fail_count = fail_count + 1;
            $error("evict_valid high outside a miss response");
        end

    a_no_resp_in_sweep: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> init_done)
        else begin
            fail_count = fail_count + 1;
            $error("response seen before init_done");
        end

endmodule

bind l2_tag_pipe l2_tag_pipe_assertions u_checks (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid   (req_valid),
    .init_done   (init_done),
    .resp_valid  (resp_valid),
    .resp_hit    (resp_hit),
    .evict_valid (evict_valid)
);

`default_nettype wire

// ==== testbench/l2_tag_pipe_tb.sv ====
// testbench for the L2 tag pipeline, runs directed and random requests against a set model
`default_nettype none
`timescale 1ns/10ps

module l2_tag_pipe_tb;
    import l2_cache_pkg::*;
    import l2_req_pkg::*;

    localparam int SETS        = 512;
    localparam int CYCLE_LIMIT = 1000 + SETS;         // sweep plus about 500 requests and gaps

    typedef struct packed {
        logic chk_way;                                // way undefined on an invalidate miss
        logic hit;
        way_t way;
        logic evict;
        tag_t etag;
    } expect_t;

    logic   clk;
    logic   rst_n;
    logic   req_valid;
    l2_op_t req_op;
    index_t req_index;
    tag_t   req_tag;
    logic   init_done;
    logic   resp_valid;
    logic   resp_hit;
    way_t   resp_way;
    logic   evict_valid;
    tag_t   evict_tag;

    // reference state of every set
    logic [3:0] m_valid [SETS];
    logic [3:0] m_dirty [SETS];
    tag_t       m_tag [SETS][4];
    logic [2:0] m_plru [SETS];

    expect_t expected [$];                            // responses still in flight
    int      seed = 32'h4560f271;
    int      cycles = 0;

    l2_tag_pipe #(
        .SETS (SETS)
    ) uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_op      (req_op),
        .req_index   (req_index),
        .req_tag     (req_tag),
        .init_done   (init_done),
        .resp_valid  (resp_valid),
        .resp_hit    (resp_hit),
        .resp_way    (resp_way),
        .evict_valid (evict_valid),
        .evict_tag   (evict_tag)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        abort_run();
    endtask

    // tree bits on the path of the used way point to the other side
    function automatic logic [2:0] tree_after_access(input logic [2:0] t, input int way);
        logic [2:0] n;
        n = t;
        if (way < 2) begin
            n[0] = 1'b1;
            n[1] = (way == 0);
        end else begin
            n[0] = 1'b0;
            n[2] = (way == 2);
        end
        return n;
    endfunction

    function automatic int pick_victim(input logic [3:0] v, input logic [2:0] t);
        for (int w = 0; w < 4; w++) begin
            if (!v[w]) begin
                return w;                             // first free way
            end
        end
        if (t[0]) begin
            return t[2] ? 3 : 2;
        end
        return t[1] ? 1 : 0;
    endfunction

    // apply one request to the model and queue its response
    task automatic model_access(input l2_op_t op, input index_t idx, input tag_t tag);
        expect_t e;
        int      hw;
        int      vw;
        hw = -1;
        for (int w = 0; w < 4; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
                hw = w;
            end
        end
        e = '0;
        e.chk_way = 1'b1;
        if (hw >= 0) begin
            e.hit = 1'b1;
            e.way = way_t'(hw);
            if (op == OP_INVAL) begin
                m_valid[idx][hw] = 1'b0;
                m_dirty[idx][hw] = 1'b0;
            end else begin
                if (op == OP_STORE) begin
                    m_dirty[idx][hw] = 1'b1;
                end
                m_plru[idx] = tree_after_access(m_plru[idx], hw);
            end
        end else if (op == OP_INVAL) begin
            e.chk_way = 1'b0;                         // nothing changes
        end else begin
            vw = pick_victim(m_valid[idx], m_plru[idx]);
            e.way   = way_t'(vw);
            e.evict = m_valid[idx][vw] && m_dirty[idx][vw];
            e.etag  = m_tag[idx][vw];
            m_valid[idx][vw] = 1'b1;
            m_dirty[idx][vw] = (op == OP_STORE);
            m_tag[idx][vw]   = tag;
            m_plru[idx]      = tree_after_access(m_plru[idx], vw);
        end
        expected.push_back(e);
    endtask

    task automatic send(input l2_op_t op, input index_t idx, input tag_t tag);
        @(posedge clk);
        req_valid <= 1'b1;
        req_op    <= op;
        req_index <= idx;
        req_tag   <= tag;
        model_access(op, idx, tag);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            req_valid <= 1'b0;
        end
    endtask

    function automatic bit response_matches(input expect_t e);
        bit ok;
        ok = (resp_hit === e.hit) && (evict_valid === e.evict);
        if (e.chk_way) begin
            ok = ok && (resp_way === e.way);
        end
        if (e.evict) begin
            ok = ok && (evict_tag === e.etag);
        end
        return ok;
    endfunction

    // outputs settle after the rising edge, compare in the middle of the cycle
    always @(negedge clk) begin : check_response
        expect_t e;
        if (rst_n && resp_valid) begin
            if (expected.size() == 0) begin
                report_mismatch("response with no request outstanding");
            end else begin
                e = expected.pop_front();
                assert (response_matches(e))
                    else report_mismatch($sformatf(
                        "got %0b/%0d/%0b/%h, expected %0b/%0d/%0b/%h (hit/way/evict/tag)",
                        resp_hit, resp_way, evict_valid, evict_tag,
                        e.hit, e.way, e.evict, e.etag));
            end
        end
    end

    always @(negedge clk) begin
        if (uut.u_checks.fail_count != 0) begin
            $display("a bound protocol assertion failed, see the message above");
            abort_run();
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    initial begin
        logic [31:0] r;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_op    = OP_LOAD;
        req_index = '0;
        req_tag   = '0;
        for (int s = 0; s < SETS; s++) begin
            m_valid[s] = '0;
            m_dirty[s] = '0;
            m_plru[s]  = '0;
            for (int w = 0; w < 4; w++) begin
                m_tag[s][w] = '0;
            end
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        // dropped during the sweep, so no response expected
        @(posedge clk);
        req_valid <= 1'b1;
        req_op    <= OP_STORE;
        req_index <= 9'd3;
        req_tag   <= 18'h00a1;
        idle(1);
        do @(negedge clk); while (!init_done);

        send(OP_LOAD, 9'd3, 18'h00a1);                // cold miss, way 0
        idle(3);
        send(OP_LOAD, 9'd3, 18'h00a1);                // hit after fill
        send(OP_STORE, 9'd3, 18'h00a1);               // store hit, now dirty
        idle(3);
        send(OP_STORE, 9'd3, 18'h00b2);
        send(OP_LOAD, 9'd3, 18'h00c3);
        send(OP_STORE, 9'd3, 18'h00d4);               // set full
        idle(2);
        send(OP_LOAD, 9'd3, 18'h00e5);                // tree victims from here on
        send(OP_LOAD, 9'd3, 18'h00f6);
        send(OP_STORE, 9'd3, 18'h0107);
        send(OP_LOAD, 9'd3, 18'h0118);
        send(OP_LOAD, 9'd3, 18'h0129);
        idle(3);

        send(OP_LOAD, 9'd10, 18'h0b01);               // fill then same tag next cycle
        send(OP_LOAD, 9'd10, 18'h0b01);
        send(OP_STORE, 9'd10, 18'h0b02);
        send(OP_STORE, 9'd10, 18'h0b02);
        send(OP_LOAD, 9'd10, 18'h0b03);
        send(OP_STORE, 9'd10, 18'h0b04);
        send(OP_LOAD, 9'd10, 18'h0b05);               // back-to-back victims
        send(OP_LOAD, 9'd10, 18'h0b06);
        send(OP_LOAD, 9'd10, 18'h0b02);
        idle(3);

        send(OP_INVAL, 9'd3, m_tag[3][2]);
        send(OP_INVAL, 9'd3, m_tag[3][1]);
        send(OP_LOAD, 9'd3, 18'h0200);                // lowest invalid way is 1
        send(OP_INVAL, 9'd3, 18'h3ffff);              // miss, no change
        send(OP_LOAD, 9'd3, 18'h0201);
        idle(3);

        for (int i = 0; i < 400; i++) begin
            r = $random(seed);
            send(r[0] ? OP_STORE : OP_LOAD, index_t'(9'd40 + r[2:1]),
                 tag_t'(18'h2a00 + (r[10:4] % 6)));
            if (r[15:13] == 3'd0) begin
                idle(1);                              // occasional bubble
            end
        end
        idle(4);
        while (expected.size() != 0) @(negedge clk);

        if (uut.u_checks.fail_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("a bound protocol assertion failed near the end of the run");
            abort_run();
        end
    end

endmodule

`default_nettype wire
